/* rtl/pool_pkg.sv */
package pool_pkg;

    localparam int FM_WIDTH    = 6;             // input map columns
    localparam int FM_HEIGHT   = 6;             // input map rows
    localparam int OUT_WIDTH   = 3;             // windows per row pair
    localparam int OUT_COUNT   = 9;             // results per frame
    localparam int LB_DEPTH    = 12;            // two rows of slots, also the sender's credits
    localparam int OUT_CREDITS = 2;             // output credits held after reset
    localparam int DATA_W      = 32;

    // one pixel beat from upstream
    typedef struct packed {
        logic                     valid;
        logic signed [DATA_W-1:0] data;
    } pool_pixel_t;

    // one pooled result beat to downstream
    typedef struct packed {
        logic                     valid;
        logic                     last;         // final window of the frame
        logic [3:0]               index;        // window number in raster order
        logic signed [DATA_W-1:0] data;
    } pool_result_t;

    typedef enum logic [1:0] {
        AVG_IDLE,                               // hold the sum
        AVG_LOAD,                               // first term of a window
        AVG_ACC                                 // add one more term
    } avg_op_e;

    typedef enum logic [2:0] {
        WAIT_ROWS,
        FEED,
        SETTLE,
        EMIT,
        RELEASE,
        DONE_ROWS
    } seq_state_e;

endpackage

/* rtl/avg_pool_unit.sv */
`timescale 1ns/1ps

module avg_pool_unit import pool_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  avg_op_e                  avg_op,
    input  logic signed [DATA_W-1:0] avg_in,
    output logic signed [DATA_W-1:0] avg_out,
    output logic                     avg_valid
);

    logic signed [DATA_W+1:0] sum;              // two guard bits hold four full-scale terms
    logic signed [DATA_W+1:0] next_sum;
    logic signed [DATA_W+1:0] shifted;
    logic signed [DATA_W+1:0] in_ext;
    logic [1:0]               term_cnt;         // terms taken so far, wraps on the fourth
    logic                     active;           // a window sum is in progress
    logic                     fourth;

    assign in_ext   = {{2{avg_in[DATA_W-1]}}, avg_in};
    assign next_sum = sum + in_ext;
    assign shifted  = next_sum >>> 2;           // arithmetic shift floors toward minus infinity
    assign fourth   = (avg_op == AVG_ACC) && (term_cnt == 2'd3);

    always_ff @(posedge clk) begin
        if (avg_op == AVG_LOAD) begin
            sum <= in_ext;
        end else if (avg_op == AVG_ACC) begin
            sum <= next_sum;
        end
        if (fourth) begin
            avg_out <= shifted[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            term_cnt  <= '0;
            active    <= 1'b0;
            avg_valid <= 1'b0;
        end else begin
            avg_valid <= fourth;                // single cycle pulse
            case (avg_op)
                AVG_LOAD: begin
                    term_cnt <= 2'd1;
                    active   <= 1'b1;
                end
                AVG_ACC: begin
                    term_cnt <= term_cnt + 2'd1;
                    if (fourth) begin
                        active <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    // the sequencer must open every window with a load
    a_acc_needs_load: assert property (
        @(posedge clk) disable iff (rst)
        (avg_op == AVG_ACC) |-> active
    );

endmodule

/* rtl/pool_line_buffer.sv */
`timescale 1ns/1ps

module pool_line_buffer import pool_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  pool_pixel_t              in_beat,
    output logic                     in_credit,
    input  logic                     rd_row,
    input  logic [2:0]               rd_col,
    output logic signed [DATA_W-1:0] rd_data,
    output logic                     rows_ready,
    input  logic                     release_rows
);

    logic signed [DATA_W-1:0] lb [0:1][0:FM_WIDTH-1];   // two rows of pixels
    logic [3:0]               wr_ptr;                   // next slot, counts up to LB_DEPTH
    logic [3:0]               credit_pend;              // credits still to hand back
    logic                     wr_row;
    logic [2:0]               wr_col;
    logic                     wr_last;

    assign wr_row  = 1'(wr_ptr / FM_WIDTH);
    assign wr_col  = 3'(wr_ptr % FM_WIDTH);
    assign wr_last = (wr_ptr == 4'(LB_DEPTH - 1));

    assign rd_data = lb[rd_row][rd_col];                // combinational read for the sequencer

    always_ff @(posedge clk) begin
        if (in_beat.valid) begin
            lb[wr_row][wr_col] <= in_beat.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rows_ready  <= 1'b0;
            credit_pend <= '0;
            in_credit   <= 1'b0;
        end else begin
            in_credit <= (credit_pend != 4'd0);         // one credit pulse per cycle while pending
            if (credit_pend != 4'd0) begin
                credit_pend <= credit_pend - 4'd1;
            end

            if (release_rows) begin
                // the whole row pair is free again
                wr_ptr      <= '0;
                rows_ready  <= 1'b0;
                credit_pend <= 4'(LB_DEPTH);
            end else if (in_beat.valid) begin
                wr_ptr <= wr_ptr + 4'd1;
                if (wr_last) begin
                    rows_ready <= 1'b1;                 // high from the cycle after the twelfth write
                end
            end
        end
    end

    // the sender holds no credits while both rows are full
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        in_beat.valid |-> !rows_ready
    );

endmodule

/* rtl/pool_window_seq.sv */
`timescale 1ns/1ps

module pool_window_seq import pool_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rows_ready,
    output logic                     rd_row,
    output logic [2:0]               rd_col,
    input  logic signed [DATA_W-1:0] rd_data,
    output logic                     release_rows,
    output avg_op_e                  avg_op,
    output logic signed [DATA_W-1:0] avg_in,
    input  logic signed [DATA_W-1:0] avg_out,
    input  logic                     avg_valid,
    input  logic                     out_credit,
    output pool_result_t             out_beat
);

    seq_state_e               state;
    logic [1:0]               feed_cnt;         // which of the four window pixels
    logic [1:0]               win_col;          // window column in the row pair
    logic [1:0]               pair;             // row pair within the frame
    logic [1:0]               credit_cnt;       // output credits held
    logic signed [DATA_W-1:0] res_data;         // holds the average until it can be sent
    logic [3:0]               win_index;
    logic                     last_col;
    logic                     send;

    assign win_index = 4'(pair * OUT_WIDTH + win_col);
    assign last_col  = (win_col == 2'(OUT_WIDTH - 1));
    assign send      = (state == EMIT) && (credit_cnt != 2'd0);

    // order is top-left, top-right, bottom-left, bottom-right
    assign rd_row = feed_cnt[1];
    assign rd_col = {win_col, feed_cnt[0]};
    assign avg_in = rd_data;

    assign avg_op = (state != FEED)     ? AVG_IDLE :
                    (feed_cnt == 2'd0)  ? AVG_LOAD : AVG_ACC;

    assign release_rows = (state == RELEASE);

    always_ff @(posedge clk) begin
        if (avg_valid) begin
            res_data <= avg_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= WAIT_ROWS;
            feed_cnt   <= '0;
            win_col    <= '0;
            pair       <= '0;
            credit_cnt <= 2'(OUT_CREDITS);
            out_beat   <= '0;
        end else begin
            out_beat.valid <= 1'b0;

            case ({out_credit, send})
                2'b10:   credit_cnt <= credit_cnt + 2'd1;
                2'b01:   credit_cnt <= credit_cnt - 2'd1;
                default: ;                      // both or neither leave the count unchanged
            endcase

            case (state)
                WAIT_ROWS: begin
                    if (rows_ready) begin
                        feed_cnt <= '0;
                        state    <= FEED;
                    end
                end
                FEED: begin
                    feed_cnt <= feed_cnt + 2'd1;
                    if (feed_cnt == 2'd3) begin
                        state <= SETTLE;
                    end
                end
                SETTLE: begin
                    state <= EMIT;              // average lands in res_data this cycle
                end
                EMIT: begin
                    if (send) begin
                        out_beat <= '{valid: 1'b1,
                                      last:  (win_index == 4'(OUT_COUNT - 1)),
                                      index: win_index,
                                      data:  res_data};
                        if (last_col) begin
                            state <= RELEASE;
                        end else begin
                            win_col <= win_col + 2'd1;
                            state   <= FEED;
                        end
                    end
                end
                RELEASE: begin
                    win_col <= '0;
                    pair    <= (pair == 2'(FM_HEIGHT / 2 - 1)) ? 2'd0 : pair + 2'd1;
                    state   <= DONE_ROWS;
                end
                DONE_ROWS: begin
                    if (!rows_ready) begin
                        state <= WAIT_ROWS;     // line buffer has dropped the old pair
                    end
                end
                default: state <= WAIT_ROWS;
            endcase
        end
    end

    // downstream never returns more credits than it was given
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= 2'(OUT_CREDITS)
    );

    // the averaging unit answers in the one settle cycle after the fourth pixel
    a_avg_in_settle: assert property (
        @(posedge clk) disable iff (rst)
        (state == SETTLE) |-> avg_valid
    );

endmodule

/* rtl/pool_layer.sv */
`timescale 1ns/1ps

module pool_layer import pool_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  pool_pixel_t  in_beat,
    output logic         in_credit,
    output pool_result_t out_beat,
    input  logic         out_credit
);

    logic                     rd_row;
    logic [2:0]               rd_col;
    logic signed [DATA_W-1:0] rd_data;
    logic                     rows_ready;
    logic                     release_rows;     // row pair fully pooled
    avg_op_e                  avg_op;
    logic signed [DATA_W-1:0] avg_in;
    logic signed [DATA_W-1:0] avg_out;
    logic                     avg_valid;

    pool_line_buffer u_line_buffer (
        .clk          (clk),
        .rst          (rst),
        .in_beat      (in_beat),
        .in_credit    (in_credit),
        .rd_row       (rd_row),
        .rd_col       (rd_col),
        .rd_data      (rd_data),
        .rows_ready   (rows_ready),
        .release_rows (release_rows)
    );

    pool_window_seq u_window_seq (
        .clk          (clk),
        .rst          (rst),
        .rows_ready   (rows_ready),
        .rd_row       (rd_row),
        .rd_col       (rd_col),
        .rd_data      (rd_data),
        .release_rows (release_rows),
        .avg_op       (avg_op),
        .avg_in       (avg_in),
        .avg_out      (avg_out),
        .avg_valid    (avg_valid),
        .out_credit   (out_credit),
        .out_beat     (out_beat)
    );

    avg_pool_unit u_avg_pool (
        .clk       (clk),
        .rst       (rst),
        .avg_op    (avg_op),
        .avg_in    (avg_in),
        .avg_out   (avg_out),
        .avg_valid (avg_valid)
    );

endmodule

/* test/pool_layer_tb.sv */
`timescale 1ns/1ps

module pool_layer_tb import pool_pkg::*; ();

    localparam int FRAMES      = 4;
    localparam int FRAME_PIX   = FM_WIDTH * FM_HEIGHT;
    localparam int FRAME_WORDS = FRAME_PIX + OUT_COUNT;     // pixels, then expected averages
    localparam int WAIT_LIMIT  = 5000;                      // cycles allowed for any one wait
    localparam int LONG_STALL  = 40;

    logic         clk;
    logic         rst;
    pool_pixel_t  in_beat;
    logic         in_credit;
    pool_result_t out_beat;
    logic         out_credit;

    logic [31:0] stim_mem [0:FRAMES*FRAME_WORDS-1];
    int          seed     = 32'h193f80c5;
    int          sent     = 0;                              // pixels driven by the sender
    int          returns  = 0;                              // in_credit pulses seen
    int          received = 0;                              // results seen
    int          returned = 0;                              // out_credit pulses driven
    int          errors   = 0;
    bit          timed_out = 1'b0;

    pool_layer dut (
        .clk        (clk),
        .rst        (rst),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] stim_addr(input int frame, input int pos);
        return 8'(frame * FRAME_WORDS + pos);
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic check_idle_outputs(input string phase);
        if (out_beat.valid !== 1'b0) begin
            report_error({"out_beat.valid is not low ", phase});
        end
        if (in_credit !== 1'b0) begin
            report_error({"in_credit is not low ", phase});
        end
    endtask

    // every in_credit pulse must cover a pixel that was actually sent
    always @(posedge clk) begin
        if (!rst && in_credit === 1'b1) begin
            if (returns >= sent) begin
                report_error("in_credit pulse with no pixel outstanding");
            end
            returns <= returns + 1;
        end
    end

    always @(posedge clk) begin
        int          frame;
        int          k;
        logic [31:0] expected;
        if (!rst && out_beat.valid === 1'b1) begin
            frame = received / OUT_COUNT;
            k     = received % OUT_COUNT;
            if (received >= FRAMES * OUT_COUNT) begin
                report_error("result beyond the last frame");
            end else begin
                expected = stim_mem[stim_addr(frame, FRAME_PIX + k)];
                if (out_beat.data !== expected) begin
                    report_mismatch($sformatf("frame %0d window %0d data", frame, k),
                                    expected, out_beat.data);
                end
                if (out_beat.index !== 4'(k)) begin
                    report_mismatch($sformatf("frame %0d index", frame), k, out_beat.index);
                end
                if (out_beat.last !== (k == OUT_COUNT - 1)) begin
                    report_mismatch($sformatf("frame %0d window %0d last", frame, k),
                                    k == OUT_COUNT - 1, out_beat.last);
                end
            end
            if (received + 1 - returned > OUT_CREDITS) begin
                report_mismatch("results without a returned credit", OUT_CREDITS,
                                received + 1 - returned);
            end
            received <= received + 1;
        end
    end

    task automatic send_frames();
        int p;
        int gap;
        int waited;
        for (p = 0; p < FRAMES * FRAME_PIX; p++) begin
            // the last two frames stream with no gaps at all
            gap = (p < 2 * FRAME_PIX) ? int'($unsigned($random(seed)) % 4) : 0;
            while (gap > 0) begin
                in_beat.valid <= 1'b0;
                @(posedge clk);
                gap--;
            end
            waited = 0;
            while (!timed_out && LB_DEPTH + returns - sent <= 0) begin
                in_beat.valid <= 1'b0;
                @(posedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_error("timed out waiting for an input credit");
                    timed_out = 1'b1;
                end
            end
            if (timed_out) begin
                in_beat.valid <= 1'b0;
                return;
            end
            in_beat.valid <= 1'b1;
            in_beat.data  <= stim_mem[stim_addr(p / FRAME_PIX, p % FRAME_PIX)];
            sent          <= sent + 1;
            @(posedge clk);
        end
        in_beat.valid <= 1'b0;
    endtask

    task automatic return_credits();
        int k;
        int r;
        int waited;
        for (k = 0; k < FRAMES * OUT_COUNT; k++) begin
            waited = 0;
            while (!timed_out && received <= returned) begin
                @(posedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_error("timed out waiting for a result to consume");
                    timed_out = 1'b1;
                end
            end
            if (timed_out) begin
                return;
            end
            r = int'($unsigned($random(seed)) % 16);
            repeat ((r < 2) ? LONG_STALL : r % 4) @(posedge clk);   // now and then a long stall
            out_credit <= 1'b1;
            returned   <= returned + 1;
            @(posedge clk);
            out_credit <= 1'b0;
        end
    endtask

    task automatic wait_results();
        int f;
        int waited;
        for (f = 0; f < FRAMES; f++) begin
            waited = 0;
            while (!timed_out && received < (f + 1) * OUT_COUNT) begin
                @(posedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_error($sformatf("timed out waiting for the results of frame %0d", f));
                    timed_out = 1'b1;
                end
            end
            waited = 0;
            while (!timed_out && returns < (f + 1) * FRAME_PIX) begin
                @(posedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_error($sformatf("timed out waiting for input credits of frame %0d", f));
                    timed_out = 1'b1;
                end
            end
            if (timed_out) begin
                return;
            end
            if (returns != (f + 1) * FRAME_PIX) begin
                report_mismatch($sformatf("in_credit pulses after frame %0d", f),
                                (f + 1) * FRAME_PIX, returns);
            end
        end
    endtask

    initial begin
        int i;
        rst        = 1'b1;
        in_beat    = '0;
        out_credit = 1'b0;
        $readmemh("test/pool_stimulus.txt", stim_mem);
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_idle_outputs("during reset");             // first edge only loads the reset
            end
        end
        rst <= 1'b0;
        for (i = 0; i < 2; i++) begin
            @(posedge clk);
            check_idle_outputs("after reset");
        end
        if ($isunknown(stim_mem[stim_addr(FRAMES - 1, FRAME_WORDS - 1)])) begin
            report_error("stimulus file test/pool_stimulus.txt is missing or incomplete");
        end else begin
            fork
                send_frames();
                return_credits();
                wait_results();
            join
            if (received != FRAMES * OUT_COUNT) begin
                report_mismatch("results received", FRAMES * OUT_COUNT, received);
            end
            if (LB_DEPTH + returns - sent != LB_DEPTH) begin
                report_mismatch("sender credits at end", LB_DEPTH, LB_DEPTH + returns - sent);
            end
        end
        $display("Summary: %0d results, %0d input credits, %0d errors", received, returns, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* test/pool_stimulus.txt */
// four frames: a line of 36 pixels in raster order, then a line of the 9 expected averages
// every value is a 32-bit two's complement word in hex
0 1 2 3 4 5 6 7 8 9 a b c d e f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23
3 5 7 f 11 13 1b 1d 1f
00000000 ffffffff fffffffe fffffffd fffffffc fffffffb fffffffa fffffff9 fffffff8 fffffff7 fffffff6 fffffff5 fffffff4 fffffff3 fffffff2 fffffff1 fffffff0 ffffffef ffffffee ffffffed ffffffec ffffffeb ffffffea ffffffe9 ffffffe8 ffffffe7 ffffffe6 ffffffe5 ffffffe4 ffffffe3 ffffffe2 ffffffe1 ffffffe0 ffffffdf ffffffde ffffffdd
fffffffc fffffffa fffffff8 fffffff0 ffffffee ffffffec ffffffe4 ffffffe2 ffffffe0
7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 7fffffff 80000000 7fffffff 80000000 7fffffff 80000000 00000001 00000002 fffffffd fffffffe 00000005 00000006
7fffffff 7fffffff 7fffffff 80000000 80000000 80000000 00000000 fffffffe 00000002
00000064 ffffff9c 00000003 00000000 fffffffb 0000000a 00000001 00000002 ffffffff fffffffe 00000007 ffffffe9 00001000 00002000 fffff000 00000001 00000011 00000022 00003000 00000003 00000000 00000000 ffffffee 00000033 12345678 00000000 ffffff80 0000007f 00000002 00000002 00000000 00000000 00000000 ffffffff 00000002 00000003
00000000 00000000 fffffffd 00001800 fffffc00 00000015 048d159e ffffffff 00000002

/* verilog.f */
rtl/pool_pkg.sv
rtl/avg_pool_unit.sv
rtl/pool_line_buffer.sv
rtl/pool_window_seq.sv
rtl/pool_layer.sv
test/pool_layer_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= pool_layer_tb
RTL_TOP    ?= pool_layer
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Checks failed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
